//--- logic/i2s_defs.svh
// constants shared by the WAV to I2S player
// include wherever widths, header layout or format tags are needed
`ifndef I2S_DEFS_SVH
`define I2S_DEFS_SVH

`define MEM_ADDR_BITS      25        // memory word address
`define SAMPLE_BITS        16        // memory word and linear sample
`define I2S_SLOT_BITS      32        // bits per channel slot
`define PLAY_VOLUME_SHIFT  2         // leading sign copies, about 12 dB down

`define WAV_HEADER_WORDS   22        // 44-byte canonical header
`define WAV_FORMAT_WORD    10        // byte 20, audio format tag

// "RIFF" read as little-endian words
`define RIFF_WORD0         16'h4952  // 'R' low, 'I' high
`define RIFF_WORD1         16'h4646  // 'F' 'F'

`define FMT_PCM            16'd1
`define FMT_ALAW           16'd6
`define FMT_ULAW           16'd7

`endif

//--- logic/wav_i2s_pkg.sv
// types for the WAV to I2S player
// import inside module bodies, scoped names on ports
`default_nettype none
`include "i2s_defs.svh"

package wav_i2s_pkg;

	typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;
	typedef logic [`SAMPLE_BITS-1:0]   pcm_word_t;
	typedef logic [7:0]                g711_byte_t;   // companded sample
	typedef logic [5:0]                slot_count_t;  // bit position within slot

	// values double as the display code
	typedef enum logic [3:0] {
		MODE_NONE = 4'h0,
		MODE_PCM  = 4'h1,
		MODE_ULAW = 4'h2,  // "2" for mu
		MODE_ALAW = 4'hA
	} play_mode_t;

	typedef struct packed {
		logic      rd;    // held until ack
		mem_addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic      ack;   // data valid this cycle
		pcm_word_t data;
	} mem_rsp_t;

	typedef struct packed {
		logic sclk;
		logic lrclk;
	} codec_clk_t;

	typedef enum logic {FETCH_IDLE, FETCH_READ} fetch_state_t;
	typedef enum logic [1:0] {DET_HEADER, DET_PLAY, DET_STOP} detect_state_t;
	typedef enum logic [1:0] {SER_WAIT_FRAME, SER_LEFT_SLOT, SER_RIGHT_SLOT} ser_state_t;

endpackage

`default_nettype wire

//--- logic/sample_fetch.sv
// sequential reader for the sound file in word memory
// keeps up to two words queued ahead of the consumer, address wraps
`timescale 1ns/1ps
`default_nettype none

module sample_fetch (
	input  wire logic                  clk50,
	input  wire logic                  reset,
	input  wire logic                  i2s_enable,
	output wav_i2s_pkg::mem_req_t      mem_req,
	input  wire wav_i2s_pkg::mem_rsp_t mem_rsp,
	input  wire logic                  word_take,   // pops head_word
	output logic                       word_ready,
	output wav_i2s_pkg::pcm_word_t     head_word
);
	import wav_i2s_pkg::*;

	fetch_state_t fetch_state;
	mem_addr_t    rd_addr;          // next word to read
	pcm_word_t    queue_mem [2];    // two-entry ring
	logic         head_ptr;
	logic [1:0]   fill;             // 0..2 words held
	logic         tail_ptr;
	logic         push, pop;

	assign push = (fetch_state == FETCH_READ) & mem_rsp.ack;
	assign pop = word_take & word_ready;           // ignore take on empty
	assign tail_ptr = head_ptr ^ fill[0];           // fill is never 2 on push

	assign word_ready = (fill != 2'd0);
	assign head_word = queue_mem[head_ptr];
	assign mem_req = '{rd: (fetch_state == FETCH_READ), addr: rd_addr};

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			fetch_state <= FETCH_IDLE;
			rd_addr <= '0;                          // file starts at word 0
			head_ptr <= 1'b0;
			fill <= 2'd0;
		end
		else begin
			case (fetch_state)
				FETCH_IDLE: begin
					if (i2s_enable && fill != 2'd2)  // free place, go read
						fetch_state <= FETCH_READ;
				end
				FETCH_READ: begin
					// finishes even with enable low
					if (mem_rsp.ack) begin
						fetch_state <= FETCH_IDLE;  // rd drops next cycle
						rd_addr <= rd_addr + 1'b1;
					end
				end
			endcase
			if (pop)
				head_ptr <= ~head_ptr;
			fill <= fill + {1'b0, push} - {1'b0, pop};
		end
	end

	// queue storage
	always_ff @(posedge clk50) begin
		if (push)
			queue_mem[tail_ptr] <= mem_rsp.data;
	end

endmodule

`default_nettype wire

//--- logic/wav_format_detect.sv
// eats the 44-byte WAV header, checks RIFF and the format tag
// then hands data words to the serializer, stops for good on a bad file
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defs.svh"

module wav_format_detect (
	input  wire logic                   clk50,
	input  wire logic                   reset,
	input  wire logic                   i2s_enable,
	input  wire logic                   word_ready,
	input  wire wav_i2s_pkg::pcm_word_t head_word,
	output logic                        word_take,
	output wav_i2s_pkg::play_mode_t     play_mode,
	output logic                        data_ready,
	output wav_i2s_pkg::pcm_word_t      data_word,
	input  wire logic                   data_take
);
	import wav_i2s_pkg::*;

	detect_state_t det_state;
	logic [4:0]    hdr_idx;     // header word being taken
	logic          hdr_take;
	play_mode_t    fmt_mode;    // decode of head_word as a format tag

	// one header word per cycle while available
	assign hdr_take = i2s_enable & word_ready & (det_state == DET_HEADER);
	assign word_take = hdr_take | (data_take & data_ready);
	assign data_ready = word_ready & (det_state == DET_PLAY);
	assign data_word = head_word;

	always_comb begin
		case (head_word)
			`FMT_PCM:  fmt_mode = MODE_PCM;
			`FMT_ALAW: fmt_mode = MODE_ALAW;
			`FMT_ULAW: fmt_mode = MODE_ULAW;
			default:   fmt_mode = MODE_NONE;   // unsupported, ADPCM included
		endcase
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			det_state <= DET_HEADER;
			hdr_idx <= '0;
			play_mode <= MODE_NONE;
		end
		else if (hdr_take) begin
			hdr_idx <= hdr_idx + 1'b1;
			if (hdr_idx == 5'd0 && head_word != `RIFF_WORD0)
				det_state <= DET_STOP;           // not RIFF
			else if (hdr_idx == 5'd1 && head_word != `RIFF_WORD1)
				det_state <= DET_STOP;
			else if (hdr_idx == 5'(`WAV_FORMAT_WORD)) begin
				play_mode <= fmt_mode;           // held until reset
				if (fmt_mode == MODE_NONE)
					det_state <= DET_STOP;
			end
			else if (hdr_idx == 5'(`WAV_HEADER_WORDS - 1))
				det_state <= DET_PLAY;           // rest of header dropped
		end
	end

endmodule

`default_nettype wire

//--- logic/g711_expand.sv
// G.711 expansion of one A-law or mu-law byte to linear 16 bit
// pure combinational, ITU formulas
`timescale 1ns/1ps
`default_nettype none

module g711_expand (
	input  wire wav_i2s_pkg::g711_byte_t code,
	input  wire logic                    is_ulaw,
	output wav_i2s_pkg::pcm_word_t       sample
);
	import wav_i2s_pkg::*;

	g711_byte_t c;       // de-inverted code
	logic [2:0] seg;     // exponent
	logic [3:0] mant;
	pcm_word_t  mag;
	logic       neg;

	always_comb begin
		c = is_ulaw ? ~code : (code ^ 8'h55);   // line coding undone
		seg = c[6:4];
		mant = c[3:0];
		if (is_ulaw) begin
			// biased by 132, remove after shift
			mag = (({9'd0, mant, 3'd0} + 16'd132) << seg) - 16'd132;
			neg = c[7];                          // sign set is negative
		end
		else begin
			if (seg == 3'd0)
				mag = {8'd0, mant, 4'b1000};     // linear segment, m*16+8
			else
				mag = ({8'd0, mant, 4'd0} + 16'd264) << (seg - 3'd1);
			neg = ~c[7];                         // A-law sign clear is negative
		end
		sample = neg ? -mag : mag;
	end

endmodule

`default_nettype wire

//--- logic/i2s_serializer.sv
// I2S transmitter slaved to codec SCLK/LRCLK, all in the clk50 domain
// left slot on LRCLK low, MSB one bit after the LRCLK edge
// G.711 words carry left in the low byte, right in the high byte
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defs.svh"

module i2s_serializer (
	input  wire logic                    clk50,
	input  wire logic                    reset,
	input  wire logic                    i2s_enable,
	input  wire wav_i2s_pkg::codec_clk_t codec_clk,
	input  wire wav_i2s_pkg::play_mode_t play_mode,
	input  wire logic                    data_ready,
	input  wire wav_i2s_pkg::pcm_word_t  data_word,
	output logic                         data_take,
	output logic                         din
);
	import wav_i2s_pkg::*;

	codec_clk_t  clk_s1, clk_s2, clk_prev;   // two-flop sync, then edge reg
	logic        sclk_fall, lr_fall, lr_rise;
	ser_state_t  ser_state;
	slot_count_t bit_pos;                    // bit due at next SCLK fall
	pcm_word_t   slot_sample;
	pcm_word_t   expanded;
	g711_byte_t  g711_hold;                  // right byte kept for next slot
	logic        hold_valid;
	logic        g711_mode;
	logic        left_start, right_start;
	logic [3:0]  sample_idx;
	logic        slot_bit;

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			clk_s1 <= '0;
			clk_s2 <= '0;
			clk_prev <= '0;
		end
		else begin
			clk_s1 <= codec_clk;
			clk_s2 <= clk_s1;
			clk_prev <= clk_s2;
		end
	end

	assign sclk_fall = clk_prev.sclk & ~clk_s2.sclk;
	assign lr_fall = clk_prev.lrclk & ~clk_s2.lrclk;
	assign lr_rise = ~clk_prev.lrclk & clk_s2.lrclk;

	assign g711_mode = (play_mode == MODE_ALAW) || (play_mode == MODE_ULAW);
	// first left slot needs a word, later ones may underrun
	assign left_start = i2s_enable & lr_fall & (play_mode != MODE_NONE)
		& ((ser_state == SER_RIGHT_SLOT) | ((ser_state == SER_WAIT_FRAME) & data_ready));
	assign right_start = i2s_enable & lr_rise & (ser_state == SER_LEFT_SLOT);
	assign data_take = data_ready & (left_start | (right_start & ~g711_mode));

	g711_expand expand0 (
		.code    ((ser_state == SER_LEFT_SLOT) ? g711_hold : data_word[7:0]),
		.is_ulaw (play_mode == MODE_ULAW),
		.sample  (expanded)
	);

	// sign copies, 16 sample bits MSB first, sign pad
	assign sample_idx = 4'(`PLAY_VOLUME_SHIFT + `SAMPLE_BITS - 1) - bit_pos[3:0];
	always_comb begin
		if (bit_pos < slot_count_t'(`PLAY_VOLUME_SHIFT))
			slot_bit = slot_sample[`SAMPLE_BITS-1];
		else if (bit_pos < slot_count_t'(`PLAY_VOLUME_SHIFT + `SAMPLE_BITS))
			slot_bit = slot_sample[sample_idx];
		else
			slot_bit = slot_sample[`SAMPLE_BITS-1];
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			ser_state <= SER_WAIT_FRAME;
			slot_sample <= '0;
			hold_valid <= 1'b0;
			bit_pos <= '0;
			din <= 1'b0;
		end
		else if (i2s_enable) begin
			if (left_start) begin
				ser_state <= SER_LEFT_SLOT;
				hold_valid <= data_ready;
				if (!data_ready)
					slot_sample <= '0;           // underrun, silent slot
				else
					slot_sample <= g711_mode ? expanded : data_word;
			end
			else if (right_start) begin
				ser_state <= SER_RIGHT_SLOT;
				if (g711_mode)
					slot_sample <= hold_valid ? expanded : '0;
				else
					slot_sample <= data_ready ? data_word : '0;
			end
			if (sclk_fall)
				din <= slot_bit;                 // last bit of old slot on the LR edge
			if (left_start || right_start)
				bit_pos <= '0;
			else if (sclk_fall && bit_pos != slot_count_t'(`I2S_SLOT_BITS - 1))
				bit_pos <= bit_pos + 1'b1;       // park on last pad bit
		end
	end

	always_ff @(posedge clk50) begin
		if (i2s_enable && left_start)
			g711_hold <= data_word[15:8];
	end

endmodule

`default_nettype wire

//--- logic/wav_i2s_player.sv
// WAV file player, memory reader to I2S DIN for a master-mode codec
// play_mode doubles as the 4-bit display code
`timescale 1ns/1ps
`default_nettype none

module wav_i2s_player (
	input  wire logic                    clk50,
	input  wire logic                    reset,
	input  wire logic                    i2s_enable,
	output wav_i2s_pkg::mem_req_t        mem_req,
	input  wire wav_i2s_pkg::mem_rsp_t   mem_rsp,
	input  wire wav_i2s_pkg::codec_clk_t codec_clk,
	output logic                         din,
	output wav_i2s_pkg::play_mode_t      play_mode
);
	import wav_i2s_pkg::*;

	logic      word_ready, word_take;
	pcm_word_t head_word;
	logic      data_ready, data_take;
	pcm_word_t data_word;

	sample_fetch fetch0 (
		.clk50 (clk50), .reset (reset), .i2s_enable (i2s_enable),
		.mem_req (mem_req), .mem_rsp (mem_rsp),
		.word_take (word_take), .word_ready (word_ready), .head_word (head_word)
	);

	wav_format_detect detect0 (
		.clk50 (clk50), .reset (reset), .i2s_enable (i2s_enable),
		.word_ready (word_ready), .head_word (head_word), .word_take (word_take),
		.play_mode (play_mode),
		.data_ready (data_ready), .data_word (data_word), .data_take (data_take)
	);

	i2s_serializer ser0 (
		.clk50 (clk50), .reset (reset), .i2s_enable (i2s_enable),
		.codec_clk (codec_clk), .play_mode (play_mode),
		.data_ready (data_ready), .data_word (data_word), .data_take (data_take),
		.din (din)
	);

endmodule

`default_nettype wire

//--- tb/player_checker.sv
// bus and mode assertions for the WAV to I2S player
// bound to wav_i2s_player from the testbench top
`timescale 1ns/1ps
`default_nettype none

module player_checker (
	input wire logic                    clk50,
	input wire logic                    reset,
	input wire wav_i2s_pkg::mem_req_t   mem_req,
	input wire wav_i2s_pkg::mem_rsp_t   mem_rsp,
	input wire wav_i2s_pkg::play_mode_t play_mode
);
	import wav_i2s_pkg::*;

	// read held, address steady, until ack
	property rd_held;
		@(posedge clk50) disable iff (reset)
			(mem_req.rd && !mem_rsp.ack) |=> (mem_req.rd && $stable(mem_req.addr));
	endproperty

	// next read one word on, wraps at bus width
	property addr_steps;
		@(posedge clk50) disable iff (reset)
			(mem_req.rd && mem_rsp.ack) |=>
				(mem_req.addr == $past(mem_req.addr) + mem_addr_t'(1));
	endproperty

	property mode_locked;
		@(posedge clk50) disable iff (reset)
			(play_mode != MODE_NONE) |=> $stable(play_mode);   // held until reset
	endproperty

	rd_held_a: assert property (rd_held) else $error("rd dropped or addr moved before ack");
	addr_steps_a: assert property (addr_steps) else $error("read address did not step by one");
	mode_locked_a: assert property (mode_locked) else $error("play_mode changed after being set");

endmodule

`default_nettype wire

//--- tb/tb_wav_i2s_player.sv
// testbench for the WAV to I2S player
// codec clock master, memory model with random ack delay, directed tests
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defs.svh"

module tb_wav_i2s_player;
	import wav_i2s_pkg::*;

	logic        clk50;
	logic        reset;
	logic        i2s_enable;
	mem_req_t    mem_req;
	mem_rsp_t    mem_rsp;
	codec_clk_t  codec_clk;
	logic        din;
	play_mode_t  play_mode;

	pcm_word_t   mem [4096];    // file image, word addressed
	int unsigned lcg_state;
	int          ack_wait;      // cycles to ack, -1 no read seen
	int          div_cnt;
	int          sclk_cnt;
	int          errors;
	int          checks;
	int          tests;
	logic [31:0] got_slots[$];

	wav_i2s_player dut0 (
		.clk50 (clk50), .reset (reset), .i2s_enable (i2s_enable),
		.mem_req (mem_req), .mem_rsp (mem_rsp), .codec_clk (codec_clk),
		.din (din), .play_mode (play_mode)
	);

	bind wav_i2s_player player_checker chk0 (
		.clk50 (clk50), .reset (reset), .mem_req (mem_req),
		.mem_rsp (mem_rsp), .play_mode (play_mode)
	);

	always #50 clk50 = ~clk50;   // 100 ns

	// codec master, SCLK = clk50/16, LRCLK flips every 32 SCLK on the fall
	always @(posedge clk50) begin
		#1;
		div_cnt = div_cnt + 1;
		if (div_cnt == 8)
			codec_clk.sclk = 1'b1;
		else if (div_cnt == 16) begin
			div_cnt = 0;
			codec_clk.sclk = 1'b0;
			sclk_cnt = sclk_cnt + 1;
			if (sclk_cnt == 32) begin
				sclk_cnt = 0;
				codec_clk.lrclk = ~codec_clk.lrclk;
			end
		end
	end

	// memory, ack 1 to 4 cycles after rd rises
	always @(posedge clk50) begin
		#1;
		mem_rsp = '0;
		if (!mem_req.rd)
			ack_wait = -1;
		else begin
			if (ack_wait < 0)
				ack_wait = int'(next_rand() % 4);
			if (ack_wait == 0) begin
				mem_rsp.ack = 1'b1;
				mem_rsp.data = mem[mem_req.addr[11:0]];
				ack_wait = -1;   // rd low next cycle
			end
			else
				ack_wait = ack_wait - 1;
		end
	end

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// G.711 mu-law, byte inverted, bias 0x84
	function automatic pcm_word_t ulaw_ref(input g711_byte_t code);
		int u;
		int t;
		u = int'(~code) & 255;
		t = (((u & 15) << 3) + 132) << ((u >> 4) & 7);
		return pcm_word_t'((u & 128) != 0 ? 132 - t : t - 132);
	endfunction

	// G.711 A-law, even bits inverted
	function automatic pcm_word_t alaw_ref(input g711_byte_t code);
		int a;
		int seg;
		int t;
		a = int'(code ^ 8'h55);
		seg = (a >> 4) & 7;
		t = (a & 15) << 4;
		if (seg == 0)
			t = t + 8;
		else
			t = (t + 264) << (seg - 1);
		return pcm_word_t'((a & 128) != 0 ? t : -t);
	endfunction

	// sign copies, sample MSB first, sign pad
	function automatic logic [31:0] slot_pattern(input pcm_word_t s);
		return {{`PLAY_VOLUME_SHIFT{s[15]}}, s, {(32 - 16 - `PLAY_VOLUME_SHIFT){s[15]}}};
	endfunction

	task automatic cycles(input int n);
		repeat (n) @(posedge clk50);
		#1;   // drive point
	endtask

	// SCLK (sel 0) or LRCLK (sel 1) moving to level lvl
	task automatic wait_codec_edge(input bit sel, input bit lvl, output bit ok);
		int n;
		bit prev;
		bit cur;
		prev = sel ? codec_clk.lrclk : codec_clk.sclk;
		ok = 1'b0;
		for (n = 0; n < 2000 && !ok; n++) begin
			@(posedge clk50);
			#2;
			cur = sel ? codec_clk.lrclk : codec_clk.sclk;
			ok = (cur == lvl) && (prev != lvl);
			prev = cur;
		end
		if (!ok) begin
			errors++;
			$display("timeout: no %s edge within 2000 cycles", sel ? "LRCLK" : "SCLK");
		end
	endtask

	task automatic wait_mode(input play_mode_t m);
		int n;
		for (n = 0; n < 2000 && play_mode !== m; n++) begin
			@(posedge clk50);
			#2;
		end
		checks++;
		if (play_mode !== m) begin
			errors++;
			$display("ERROR at %0t: play_mode got %h expected %h", $time, play_mode, m);
		end
	endtask

	// reset just after LRCLK rises, so the header is in before the next fall
	task automatic reset_dut();
		bit ok;
		wait_codec_edge(1'b1, 1'b1, ok);
		cycles(1);
		reset = 1'b1;
		i2s_enable = 1'b1;
		cycles(16);
		reset = 1'b0;
	endtask

	task automatic build_file(input pcm_word_t w0, input pcm_word_t w1, input pcm_word_t fmt);
		int a;
		for (a = 0; a < 4096; a++)
			mem[12'(a)] = pcm_word_t'(next_rand());   // header filler and data
		mem[12'd0] = w0;
		mem[12'd1] = w1;
		mem[12'(`WAV_FORMAT_WORD)] = fmt;
	endtask

	// n slots from the next LRCLK move to lr_level, din taken on SCLK rises
	task automatic capture_slots(input bit lr_level, input int n);
		logic [31:0] slot;
		int b;
		bit ok;
		slot = '0;
		got_slots.delete();
		wait_codec_edge(1'b1, lr_level, ok);
		if (ok)
			wait_codec_edge(1'b0, 1'b1, ok);   // last bit of the slot before
		for (b = 0; b < 32 * n && ok; b++) begin
			wait_codec_edge(1'b0, 1'b1, ok);
			slot = {slot[30:0], din};
			if (b % 32 == 31)
				got_slots.push_back(slot);
		end
	endtask

	// slot i against data word first+i (PCM) or a byte of word first+i/2
	task automatic check_slots(input play_mode_t m, input int first, input int n);
		pcm_word_t  w;
		pcm_word_t  s;
		g711_byte_t c;
		int         i;
		for (i = 0; i < n; i++) begin
			w = mem[12'(`WAV_HEADER_WORDS + first + (m == MODE_PCM ? i : i / 2))];
			c = (i % 2 == 0) ? w[7:0] : w[15:8];   // left low, right high
			if (m == MODE_PCM)
				s = w;
			else if (m == MODE_ULAW)
				s = ulaw_ref(c);
			else
				s = alaw_ref(c);
			checks++;
			if (i >= got_slots.size()) begin
				errors++;
				$display("slot %0d was never captured", i);
			end
			else if (got_slots[i] !== slot_pattern(s)) begin
				errors++;
				$display("ERROR at %0t: din slot %0d got %h expected %h",
					$time, i, got_slots[i], slot_pattern(s));
			end
		end
	endtask

	task automatic print_result(input string name, input int err0);
		tests++;
		$display("test %s: %0d errors", name, errors - err0);
	endtask

	task automatic play_and_compare(input string name, input pcm_word_t fmt,
		input play_mode_t m);
		int err0;
		err0 = errors;
		build_file(`RIFF_WORD0, `RIFF_WORD1, fmt);
		reset_dut();
		wait_mode(m);
		capture_slots(1'b0, 8);
		check_slots(m, 0, 8);
		print_result(name, err0);
	endtask

	task automatic reject_bad_file(input string name, input pcm_word_t w0,
		input pcm_word_t fmt);
		int err0;
		int n;
		err0 = errors;
		build_file(w0, `RIFF_WORD1, fmt);
		reset_dut();
		for (n = 0; n < 700 && errors == err0; n++) begin
			@(posedge clk50);
			#2;
			checks++;
			if (play_mode !== MODE_NONE) begin
				errors++;
				$display("ERROR at %0t: play_mode got %h expected 0", $time, play_mode);
			end
			if (din !== 1'b0) begin
				errors++;
				$display("ERROR at %0t: din got %b expected 0", $time, din);
			end
			// header stop plus two refills is well inside 100 cycles
			if (n >= 100 && mem_req.rd !== 1'b0) begin
				errors++;
				$display("ERROR at %0t: mem_req.rd got %b expected 0", $time, mem_req.rd);
			end
		end
		print_result(name, err0);
	endtask

	task automatic pause_and_resume();
		int        err0;
		int        n;
		bit        ok;
		mem_addr_t hold_addr;
		err0 = errors;
		hold_addr = '0;
		build_file(`RIFF_WORD0, `RIFF_WORD1, `FMT_PCM);
		reset_dut();
		wait_mode(MODE_PCM);
		wait_codec_edge(1'b1, 1'b0, ok);   // left slot start, word 22 taken 3 cycles on
		cycles(3);
		i2s_enable = 1'b0;                 // queue has a free place, refill not yet issued
		for (n = 0; n < 200 && errors == err0; n++) begin
			@(posedge clk50);
			#2;
			if (n == 10)
				hold_addr = mem_req.addr;   // outstanding read done by now
			if (n >= 10) begin
				checks++;
				if (mem_req.rd !== 1'b0) begin
					errors++;
					$display("ERROR at %0t: mem_req.rd got %b expected 0", $time, mem_req.rd);
				end
				if (mem_req.addr !== hold_addr) begin
					errors++;
					$display("ERROR at %0t: mem_req.addr got %h expected %h",
						$time, mem_req.addr, hold_addr);
				end
			end
		end
		cycles(1);
		i2s_enable = 1'b1;
		capture_slots(1'b1, 4);   // from the right slot on, words 23 up
		check_slots(MODE_PCM, 1, 4);
		print_result("enable", err0);
	endtask

	initial begin
		clk50 = 1'b0;
		reset = 1'b1;
		i2s_enable = 1'b0;
		mem_rsp = '0;
		codec_clk = '0;
		div_cnt = 0;
		sclk_cnt = 0;
		ack_wait = -1;
		lcg_state = 12;
		errors = 0;
		checks = 0;
		tests = 0;
		play_and_compare("pcm", `FMT_PCM, MODE_PCM);
		play_and_compare("ulaw", `FMT_ULAW, MODE_ULAW);
		play_and_compare("alaw", `FMT_ALAW, MODE_ALAW);
		reject_bad_file("no_riff", 16'h0000, `FMT_PCM);
		reject_bad_file("format_3", `RIFF_WORD0, 16'd3);
		pause_and_resume();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/wav_i2s_pkg.sv
logic/sample_fetch.sv
logic/wav_format_detect.sv
logic/g711_expand.sv
logic/i2s_serializer.sv
logic/wav_i2s_player.sv
tb/player_checker.sv
tb/tb_wav_i2s_player.sv

//--- run_sim.sh
#!/bin/sh
# builds the player testbench with Verilator, runs it, looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_wav_i2s_player -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_wav_i2s_player)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1
